/* list.f */
src/frontend_pkg.sv
src/fetch_pc_gen.sv
src/apb_fetch.sv
src/inst_queue.sv
src/inst_decoder.sv
src/frontend_top.sv
verification/apb_imem_model.sv
verification/frontend_tb.sv

/* run.sh */
#!/bin/sh
# build the frontend testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps --top-module frontend_tb -f list.f \
    && ./obj_dir/Vfrontend_tb | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/frontend_tb.sv */
module frontend_tb
    import frontend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 50 * QUEUE_DEPTH + 100;
    localparam logic [31:0] SEED = 32'hd904e878;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        redirect_i;
    logic [31:0] redirect_pc_i;
    logic        idle_i;
    logic        wake_i;
    logic [1:0]  issue_num_i = 2'd0;
    logic        backend_stall_i = 1'b0;
    apb_req_t    apb_req_o;
    apb_resp_t   apb_resp_i;
    inst_t [1:0] inst_o;
    logic [1:0]  inst_valid_o;

    // reference state that follows the DUT edge by edge
    logic [31:0] exp_pc;
    logic [1:0]  avail;
    logic [1:0]  pops_now;
    logic        asleep;
    logic        asleep_d;
    logic [1:0]  hold;
    inst_t [1:0] prev_inst;
    logic        hold_stall;
    int          pops_total = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "reset";

    always #5 clk = ~clk;

    frontend_top frontend_top_inst (
        .clk, .rst_n, .redirect_i, .redirect_pc_i, .idle_i, .wake_i,
        .issue_num_i, .backend_stall_i, .apb_req_o, .apb_resp_i, .inst_o, .inst_valid_o
    );

    apb_imem_model imem_inst (.clk, .rst_n, .apb_req_i(apb_req_o), .apb_resp_o(apb_resp_i));

    // what the entry at a given pc must look like after decode
    function automatic inst_t expected_inst(input logic [31:0] pc);
        inst_t       e;
        logic [31:0] w;
        w = {pc[24:0], pc[31:25]} ^ 32'h5a5a0000;
        e = '0;
        e.entry.pc = pc;
        e.entry.word = w;
        e.entry.bus_err = (pc[11:4] == 8'hff);
        if (!e.entry.bus_err) begin
            case (w[31:26])
                6'b000000: begin
                    e.cls = REG_RRW;
                    e.regs = {w[14:10], w[9:5], w[4:0]};
                end
                6'b000001: begin
                    e.cls = REG_RW;
                    e.regs = {5'd0, w[9:5], w[4:0]};
                end
                6'b010101: begin
                    e.cls = REG_BL;
                    e.regs = {10'd0, 5'd1};
                end
                6'b010110, 6'b010111: begin
                    e.cls = REG_RR;
                    e.regs = {w[4:0], w[9:5], 5'd0};
                end
                default: e.cls = REG_NONE;
            endcase
        end
        return e;
    endfunction

    task automatic report_mismatch(input string check, input logic [127:0] expected,
                                   input logic [127:0] actual);
        errors++;
        $display("CHECK FAILED %s (%s): expected %h actual %h", cur_test, check,
                 expected, actual);
    endtask

    task automatic report_event(input string what);
        errors++;
        $display("ERROR in %s: %s", cur_test, what);
    endtask

    // entries the back end takes this cycle
    assign avail    = inst_valid_o[1] ? 2'd2 : {1'b0, inst_valid_o[0]};
    assign pops_now = backend_stall_i ? 2'd0 : (issue_num_i > avail ? avail : issue_num_i);

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc   <= RESET_PC;
            asleep   <= 1'b0;
            asleep_d <= 1'b0;
            hold     <= '0;
        end else begin
            if (redirect_i) begin
                exp_pc <= redirect_pc_i;
            end else begin
                exp_pc     <= exp_pc + {28'd0, pops_now, 2'b00};
                pops_total <= pops_total + int'(pops_now);
            end
            if (wake_i) begin
                asleep <= 1'b0;
            end else if (idle_i) begin
                asleep <= 1'b1;
            end
            asleep_d <= asleep;
            hold     <= {2{backend_stall_i && !redirect_i}} & inst_valid_o;
        end
        prev_inst <= inst_o;
    end

    for (genvar k = 0; k < 2; k++) begin : g_slot
        localparam logic [31:0] OFFS = 32'(4 * k);

        a_order: assert property (@(posedge clk) disable iff (!rst_n)
            inst_valid_o[k] |-> inst_o[k].entry.pc == exp_pc + OFFS)
            else report_mismatch("pc order", 128'($sampled(exp_pc) + OFFS),
                                 128'($sampled(inst_o[k].entry.pc)));

        a_decode: assert property (@(posedge clk) disable iff (!rst_n)
            inst_valid_o[k] |-> inst_o[k] == expected_inst(inst_o[k].entry.pc))
            else report_mismatch("word and decode",
                                 128'(expected_inst($sampled(inst_o[k].entry.pc))),
                                 128'($sampled(inst_o[k])));

        // stalled back end sees the same entry again
        a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
            hold[k] |-> inst_valid_o[k] && inst_o[k] == prev_inst[k])
            else report_mismatch("stall hold", 128'($sampled(prev_inst[k])),
                                 128'($sampled(inst_o[k])));
    end

    a_no_setup_asleep: assert property (@(posedge clk) disable iff (!rst_n)
        asleep_d |-> !(apb_req_o.psel && !apb_req_o.penable))
        else report_event("a SETUP phase started while the core was asleep");

    // instruction fetch only ever reads
    a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req_o.psel |-> !apb_req_o.pwrite)
        else report_event("pwrite was high during an instruction fetch");

    // random issue width and an occasional stall
    always @(posedge clk) begin
        issue_num_i     <= 2'($urandom % 3);
        backend_stall_i <= hold_stall || (($urandom % 6) == 0);
    end

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_errors);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pops_total + n;
        while (pops_total < target) begin
            @(posedge clk);
        end
    endtask

    task automatic redirect_to(input logic [31:0] target);
        @(posedge clk);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        @(posedge clk);
        redirect_i <= 1'b0;
    endtask

    task automatic sleep_for(input int cycles);
        @(posedge clk);
        idle_i <= 1'b1;
        @(posedge clk);
        idle_i <= 1'b0;
        repeat (cycles) @(posedge clk);
        wake_i <= 1'b1;
        @(posedge clk);
        wake_i <= 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n         = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        idle_i        = 1'b0;
        wake_i        = 1'b0;
        hold_stall    = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("sequential_order");
        wait_pops(40);
        end_test();

        // bus error rows at 0xff0 and the regions of the other opcode classes
        begin_test("word_decode");
        redirect_to(32'h1cb00fe0);
        wait_pops(24);
        redirect_to(32'h1cb80100);
        wait_pops(12);
        // bne region and then a region of unknown opcodes
        redirect_to(32'h1c080000);
        wait_pops(8);
        redirect_to(32'h1cf80000);
        wait_pops(8);
        end_test();

        begin_test("back_pressure");
        @(posedge clk);
        hold_stall <= 1'b1;
        repeat (30) @(posedge clk);
        hold_stall <= 1'b0;
        wait_pops(20);
        end_test();

        // second pair of redirects lands while a transfer is in flight
        begin_test("redirect");
        redirect_to(32'h1c180000);
        wait_pops(6);
        redirect_to(32'h1c002000);
        redirect_to(32'h1c003000);
        wait_pops(10);
        end_test();

        begin_test("idle_wake");
        sleep_for(50);
        wait_pops(20);
        end_test();

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished in %s", cur_test);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verification/apb_imem_model.sv */
module apb_imem_model
    import frontend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0] wait_cnt;
    logic [1:0] waits;

    // instruction word is a fixed function of its address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[24:0], addr[31:25]} ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            apb_resp_o <= '0;
            wait_cnt   <= '0;
        end else if (apb_req_i.psel && !apb_req_i.penable) begin
            // setup phase, choose 0 to 3 wait states
            waits = 2'($urandom % 4);
            wait_cnt           <= waits;
            apb_resp_o.pready  <= (waits == 2'd0);
            apb_resp_o.prdata  <= word_at(apb_req_i.paddr);
            apb_resp_o.pslverr <= (apb_req_i.paddr[11:4] == 8'hff);
        end else if (apb_req_i.psel && apb_req_i.penable && !apb_resp_o.pready) begin
            wait_cnt          <= wait_cnt - 2'd1;
            apb_resp_o.pready <= (wait_cnt == 2'd1);
        end else begin
            // transfer done or bus idle
            apb_resp_o.pready <= 1'b0;
        end
    end

endmodule

/* src/frontend_top.sv */
module frontend_top
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        idle_i,
    input  logic        wake_i,
    input  logic [1:0]  issue_num_i,
    input  logic        backend_stall_i,
    output apb_req_t    apb_req_o,
    input  apb_resp_t   apb_resp_i,
    output inst_t [1:0] inst_o,
    output logic [1:0]  inst_valid_o
);

    logic               pc_valid;
    logic               pc_ready;
    logic [31:0]        pc;
    logic               slot_free;
    logic               push;
    fetch_entry_t       push_data;
    fetch_entry_t [1:0] q_data;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk, .rst_n, .redirect_i, .redirect_pc_i, .idle_i, .wake_i,
        .pc_ready_i(pc_ready), .pc_valid_o(pc_valid), .pc_o(pc)
    );

    apb_fetch apb_fetch_inst (
        .clk, .rst_n, .flush_i(redirect_i),
        .pc_valid_i(pc_valid), .pc_i(pc), .pc_ready_o(pc_ready),
        .slot_free_i(slot_free), .apb_req_o, .apb_resp_i,
        .push_o(push), .push_data_o(push_data)
    );

    inst_queue inst_queue_inst (
        .clk, .rst_n, .flush_i(redirect_i),
        .push_i(push), .push_data_i(push_data), .slot_free_o(slot_free),
        .issue_num_i, .backend_stall_i,
        .read_valid_o(inst_valid_o), .read_data_o(q_data)
    );

    // one decoder per issue slot
    inst_decoder inst_decoder_0 (.entry_i(q_data[0]), .inst_o(inst_o[0]));
    inst_decoder inst_decoder_1 (.entry_i(q_data[1]), .inst_o(inst_o[1]));

endmodule

/* src/inst_decoder.sv */
module inst_decoder
    import frontend_pkg::*;
(
    input  fetch_entry_t entry_i,
    output inst_t        inst_o
);

    inst_word_u word;
    reg_class_e cls;
    reg_info_t  regs;

    assign word = entry_i.word;

    // class comes from the major opcode of the immediate view
    always_comb begin
        if (entry_i.bus_err) begin
            cls = REG_NONE;
        end else begin
            case (word.imm_view.opcode)
                OP_RRW:         cls = REG_RRW;
                OP_RW:          cls = REG_RW;
                OP_BL:          cls = REG_BL;
                OP_BEQ, OP_BNE: cls = REG_RR;
                default:        cls = REG_NONE;
            endcase
        end
    end

    // register numbers from the register view
    always_comb begin
        regs = '0;
        case (cls)
            REG_RRW: begin
                regs.r_reg0 = word.reg_view.rk;
                regs.r_reg1 = word.reg_view.rj;
                regs.w_reg  = word.reg_view.rd;
            end
            REG_RW: begin
                regs.r_reg1 = word.reg_view.rj;
                regs.w_reg  = word.reg_view.rd;
            end
            REG_RR: begin
                // compare branches read rd as a source
                regs.r_reg0 = word.reg_view.rd;
                regs.r_reg1 = word.reg_view.rj;
            end
            REG_BL: begin
                regs.w_reg = 5'd1;
            end
            default: begin
                regs = '0;
            end
        endcase
    end

    assign inst_o.entry = entry_i;
    assign inst_o.cls   = cls;
    assign inst_o.regs  = regs;

endmodule

/* src/inst_queue.sv */
module inst_queue
    import frontend_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  logic               push_i,
    input  fetch_entry_t       push_data_i,
    output logic               slot_free_o,
    input  logic [1:0]         issue_num_i,
    input  logic               backend_stall_i,
    output logic [1:0]         read_valid_o,
    output fetch_entry_t [1:0] read_data_o
);

    fetch_entry_t [QUEUE_DEPTH-1:0] mem;
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] rd_ptr_nxt;
    logic [QCNT_W-1:0] count;
    logic [1:0]        avail;
    logic [1:0]        pop_num;

    // two oldest entries, pointer wraps with the power of two depth
    assign rd_ptr_nxt     = rd_ptr + QPTR_W'(1);
    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr_nxt];
    assign read_valid_o   = {count > QCNT_W'(1), count != '0};

    // clamp the issue request to what is presented
    always_comb begin
        avail = (count > QCNT_W'(1)) ? 2'd2 : count[1:0];
        if (backend_stall_i) begin
            pop_num = 2'd0;
        end else if (issue_num_i > avail) begin
            pop_num = avail;
        end else begin
            pop_num = issue_num_i;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + QPTR_W'(1);
            end
            rd_ptr <= rd_ptr + QPTR_W'(pop_num);
            count  <= count + QCNT_W'(push_i) - QCNT_W'(pop_num);
        end
    end

    // keep one slot back for the word already on the bus
    assign slot_free_o = count < QCNT_W'(QUEUE_DEPTH - 1);

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> (count != QCNT_W'(QUEUE_DEPTH)));

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= QCNT_W'(QUEUE_DEPTH));

endmodule

/* src/apb_fetch.sv */
module apb_fetch
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush_i,
    input  logic         pc_valid_i,
    input  logic [31:0]  pc_i,
    output logic         pc_ready_o,
    input  logic         slot_free_i,
    output apb_req_t     apb_req_o,
    input  apb_resp_t    apb_resp_i,
    output logic         push_o,
    output fetch_entry_t push_data_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_ACCESS
    } state_e;

    state_e      state;
    logic        discard;
    logic [31:0] pc_q;
    logic        take;
    logic        done;

    assign done = (state == S_ACCESS) && apb_resp_i.pready;
    // a new pc may follow a completing transfer straight into SETUP
    assign pc_ready_o = slot_free_i && ((state == S_IDLE) || done);
    assign take = pc_valid_i && pc_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   state <= take ? S_SETUP : S_IDLE;
                S_SETUP:  state <= S_ACCESS;
                S_ACCESS: begin
                    if (done) begin
                        state <= take ? S_SETUP : S_IDLE;
                    end
                end
                default:  state <= S_IDLE;
            endcase
        end
    end

    // APB cannot abort, so a flushed transfer runs out and is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            discard <= 1'b0;
        end else if (flush_i && (state != S_IDLE) && !done) begin
            discard <= 1'b1;
        end else if (done) begin
            discard <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q <= pc_i;
        end
    end

    assign apb_req_o.psel    = (state != S_IDLE);
    assign apb_req_o.penable = (state == S_ACCESS);
    assign apb_req_o.pwrite  = 1'b0;
    assign apb_req_o.paddr   = pc_q;

    assign push_o              = done && !discard && !flush_i;
    assign push_data_o.pc      = pc_q;
    assign push_data_o.word    = apb_resp_i.prdata;
    assign push_data_o.bus_err = apb_resp_i.pslverr;

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req_o.penable |-> apb_req_o.psel);

    // address held from SETUP until the slave answers
    a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req_o.psel && !(apb_req_o.penable && apb_resp_i.pready))
        |=> $stable(apb_req_o.paddr));

endmodule

/* src/fetch_pc_gen.sv */
module fetch_pc_gen
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        idle_i,
    input  logic        wake_i,
    input  logic        pc_ready_i,
    output logic        pc_valid_o,
    output logic [31:0] pc_o
);

    logic        idle_lock;
    logic [31:0] pc_q;

    // sleep lock, wake has priority over a new idle request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_lock <= 1'b0;
        end else if (wake_i) begin
            idle_lock <= 1'b0;
        end else if (idle_i) begin
            idle_lock <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (pc_valid_o && pc_ready_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // no fetch while asleep or while the target is being loaded
    assign pc_valid_o = !idle_lock && !redirect_i;
    assign pc_o       = pc_q;

    // offered pc must not move until the fetch master takes it
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_valid_o && !pc_ready_i && !redirect_i) |=> $stable(pc_o));

endmodule

/* src/frontend_pkg.sv */
package frontend_pkg;

    // queue size and the first fetch address
    localparam int unsigned QUEUE_DEPTH = 8;
    localparam int unsigned QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [31:0] RESET_PC = 32'h1c000000;

    // major opcodes recognized by the register decoder
    localparam logic [5:0] OP_RRW = 6'b000000;
    localparam logic [5:0] OP_RW  = 6'b000001;
    localparam logic [5:0] OP_BL  = 6'b010101;
    localparam logic [5:0] OP_BEQ = 6'b010110;
    localparam logic [5:0] OP_BNE = 6'b010111;

    // instruction word seen as register fields
    typedef struct packed {
        logic [5:0]  opcode;
        logic [10:0] mid;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg_view_t;

    // same word seen as a branch with a long offset
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] offs;
    } inst_imm_view_t;

    typedef union packed {
        inst_reg_view_t reg_view;
        inst_imm_view_t imm_view;
    } inst_word_u;

    typedef enum logic [2:0] {
        REG_NONE,
        REG_RRW,
        REG_RW,
        REG_RR,
        REG_BL
    } reg_class_e;

    // one queue slot, 65 bits
    typedef struct packed {
        logic [31:0] pc;
        inst_word_u  word;
        logic        bus_err;
    } fetch_entry_t;

    typedef struct packed {
        logic [4:0] r_reg0;
        logic [4:0] r_reg1;
        logic [4:0] w_reg;
    } reg_info_t;

    typedef struct packed {
        fetch_entry_t entry;
        reg_class_e   cls;
        reg_info_t    regs;
    } inst_t;

    // master side of the instruction bus
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
    } apb_req_t;

    // slave side of the instruction bus
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

endpackage
